// File: rtl/vis_cfg.svh
`ifndef VIS_CFG_SVH
`define VIS_CFG_SVH

// Number of 1-bit I/Q radio sources
`define VIS_RADIOS 8

// Timeslices per sample period
`define VIS_TRATE 8

// Width of a timeslice address
`define VIS_TBITS 3

// Correlator units in one chain
`define VIS_LENGTH 3

// Signed width of a partial visibility component
// Wide enough for many samples of +/-2 between emits
`define VIS_PBITS 8

// Signed width of an accumulated visibility component
`define VIS_ABITS 12

`endif

// File: rtl/vis_pkg.sv
`default_nettype none

`include "vis_cfg.svh"

package vis_pkg;

  // One bit per radio, used for the I and the Q plane
  typedef logic [`VIS_RADIOS-1:0] radio_t;

  // Timeslice address carried with every sample
  typedef logic [`VIS_TBITS-1:0] slot_t;

  // Partial visibility component from one correlator unit
  typedef logic signed [`VIS_PBITS-1:0] part_t;

  // Final visibility component after accumulation
  typedef logic signed [`VIS_ABITS-1:0] accum_t;

  // Accumulator states
  // Collect adds bursts, dump streams the sums out
  typedef enum logic {
    ST_COLLECT,
    ST_DUMP
  } accum_state_t;

endpackage

`default_nettype wire

// File: rtl/sig_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sig_stream_if;

  // Sample strobe, all other fields count only while it is high
  logic valid;
  // First sample of an integration
  logic first;
  // Only forwarded to downstream chains
  logic next;
  // Last sample before the units emit the slot sum
  logic emit;
  // With emit, the final emit of the integration
  logic last;
  // Timeslice address
  vis_pkg::slot_t addr;
  // I and Q planes
  vis_pkg::radio_t dati;
  vis_pkg::radio_t datq;

  // Producer side
  modport source(output valid, first, next, emit, last, addr, dati, datq);

  // Consumer side
  modport sink(input valid, first, next, emit, last, addr, dati, datq);

endinterface

`default_nettype wire

// File: rtl/sig_delay.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_cfg.svh"

module sig_delay (
  input  wire         clock,
  input  wire         reset_i,
  sig_stream_if.sink   up,
  sig_stream_if.source down
);

  // Control bits packed as {valid, first, next, emit, last}
  logic [4:0] ctrl_q [`VIS_LENGTH];
  // Payload stages, no reset needed
  vis_pkg::slot_t  addr_q [`VIS_LENGTH];
  vis_pkg::radio_t dati_q [`VIS_LENGTH];
  vis_pkg::radio_t datq_q [`VIS_LENGTH];

  // Control pipeline
  always_ff @(posedge clock) begin
    if (reset_i) begin
      for (int i = 0; i < `VIS_LENGTH; i++) begin
        ctrl_q[i] <= '0;
      end
    end else begin
      ctrl_q[0] <= {up.valid, up.first, up.next, up.emit, up.last};
      for (int i = 1; i < `VIS_LENGTH; i++) begin
        ctrl_q[i] <= ctrl_q[i-1];
      end
    end
  end

  // Address and data planes follow the same stages
  always_ff @(posedge clock) begin
    addr_q[0] <= up.addr;
    dati_q[0] <= up.dati;
    datq_q[0] <= up.datq;
    for (int i = 1; i < `VIS_LENGTH; i++) begin
      addr_q[i] <= addr_q[i-1];
      dati_q[i] <= dati_q[i-1];
      datq_q[i] <= datq_q[i-1];
    end
  end

  // Final stage drives the next chain
  assign {down.valid, down.first, down.next, down.emit, down.last} = ctrl_q[`VIS_LENGTH-1];
  assign down.addr = addr_q[`VIS_LENGTH-1];
  assign down.dati = dati_q[`VIS_LENGTH-1];
  assign down.datq = datq_q[`VIS_LENGTH-1];

endmodule

`default_nettype wire

// File: rtl/correlator.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_cfg.svh"

module correlator (
  input  wire              clock,
  input  wire              reset_i,
  input  wire        [1:0] unit_i,
  sig_stream_if.sink       strm,
  output logic             part_valid_o,
  output vis_pkg::part_t   part_re_o,
  output vis_pkg::part_t   part_im_o
);

  // Radio index width
  localparam int RBITS = $clog2(`VIS_RADIOS);
  // Room for slot + unit + 1 before the modulo
  localparam int SBITS = `VIS_TBITS + 2;

  // Per-timeslice running sums
  vis_pkg::part_t sum_re [`VIS_TRATE];
  vis_pkg::part_t sum_im [`VIS_TRATE];

  // Baseline selection
  logic [SBITS-1:0] b_sum;
  logic [RBITS-1:0] a_idx;
  logic [RBITS-1:0] b_idx;
  logic             ai;
  logic             aq;
  logic             bi;
  logic             bq;

  // One-sample product and updated sums
  vis_pkg::part_t prod_re;
  vis_pkg::part_t prod_im;
  vis_pkg::part_t base_re;
  vis_pkg::part_t base_im;
  vis_pkg::part_t next_re;
  vis_pkg::part_t next_im;

  // Product of two +/-1 values, +1 when the bits agree
  function automatic vis_pkg::part_t pm_one(input logic agree);
    pm_one = agree ? vis_pkg::part_t'(1) : vis_pkg::part_t'(-1);
  endfunction

  // Radio a is the slot itself
  // Radio b sits unit+1 places further round the ring
  assign a_idx = RBITS'(strm.addr);
  assign b_sum = SBITS'(strm.addr) + SBITS'(unit_i) + SBITS'(1);
  assign b_idx = RBITS'(b_sum % SBITS'(`VIS_RADIOS));

  assign ai = strm.dati[a_idx];
  assign aq = strm.datq[a_idx];
  assign bi = strm.dati[b_idx];
  assign bq = strm.datq[b_idx];

  always_comb begin
    // a * conj(b) with each bit mapped to +/-1
    prod_re = pm_one(ai ~^ bi) + pm_one(aq ~^ bq);
    prod_im = pm_one(aq ~^ bi) - pm_one(ai ~^ bq);
    // A first sample starts every slot from zero
    base_re = strm.first ? '0 : sum_re[strm.addr];
    base_im = strm.first ? '0 : sum_im[strm.addr];
    next_re = base_re + prod_re;
    next_im = base_im + prod_im;
  end

  // Slot register file
  always_ff @(posedge clock) begin
    if (strm.valid) begin
      if (strm.first) begin
        for (int i = 0; i < `VIS_TRATE; i++) begin
          sum_re[i] <= '0;
          sum_im[i] <= '0;
        end
      end
      // Emitting slot restarts, others keep adding
      if (strm.emit) begin
        sum_re[strm.addr] <= '0;
        sum_im[strm.addr] <= '0;
      end else begin
        sum_re[strm.addr] <= next_re;
        sum_im[strm.addr] <= next_im;
      end
    end
  end

  // Emit strobe, one cycle after the emit sample
  always_ff @(posedge clock) begin
    if (reset_i) begin
      part_valid_o <= 1'b0;
    end else begin
      part_valid_o <= strm.valid & strm.emit;
    end
  end

  // Emitted sum includes the emit sample itself
  always_ff @(posedge clock) begin
    if (strm.valid && strm.emit) begin
      part_re_o <= next_re;
      part_im_o <= next_im;
    end
  end

endmodule

`default_nettype wire

// File: rtl/vis_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_cfg.svh"

module vis_merge (
  input  wire                   clock,
  input  wire                   reset_i,
  input  wire [`VIS_LENGTH-1:0] par_valid_i,
  input  vis_pkg::part_t        par_re_i [`VIS_LENGTH],
  input  vis_pkg::part_t        par_im_i [`VIS_LENGTH],
  input  wire                   par_last_i,
  output logic                  seq_valid_o,
  output vis_pkg::part_t        seq_re_o,
  output vis_pkg::part_t        seq_im_o,
  output logic                  seq_last_o
);

  localparam int CBITS = $clog2(`VIS_LENGTH + 1);

  // Captured vector
  vis_pkg::part_t re_q [`VIS_LENGTH];
  vis_pkg::part_t im_q [`VIS_LENGTH];
  logic           last_q;

  // Shift-out control
  logic             busy_q;
  logic [CBITS-1:0] beat_q;
  logic             capture;

  // All units emit together, unit 0 stands for the vector
  assign capture = par_valid_i[0];

  // Payload capture, a unit that did not strobe reads as zero
  always_ff @(posedge clock) begin
    if (capture) begin
      for (int i = 0; i < `VIS_LENGTH; i++) begin
        re_q[i] <= par_valid_i[i] ? par_re_i[i] : '0;
        im_q[i] <= par_valid_i[i] ? par_im_i[i] : '0;
      end
      last_q <= par_last_i;
    end
  end

  // Beat counter walks unit 0 up to the final unit
  always_ff @(posedge clock) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      beat_q <= '0;
    end else if (capture) begin
      busy_q <= 1'b1;
      beat_q <= '0;
    end else if (busy_q) begin
      if (beat_q == CBITS'(`VIS_LENGTH - 1)) begin
        busy_q <= 1'b0;
        beat_q <= '0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // Sequential stream, burst tag held on every beat
  assign seq_valid_o = busy_q;
  assign seq_last_o  = busy_q & last_q;
  assign seq_re_o    = re_q[beat_q];
  assign seq_im_o    = im_q[beat_q];

endmodule

`default_nettype wire

// File: rtl/vis_accum.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_cfg.svh"

module vis_accum (
  input  wire                   clock,
  input  wire                   reset_i,
  input  wire                   seq_valid_i,
  input  vis_pkg::part_t        seq_re_i,
  input  vis_pkg::part_t        seq_im_i,
  input  wire                   seq_last_i,
  output logic                  vis_frame_o,
  output logic                  vis_valid_o,
  output logic                  vis_first_o,
  output logic                  vis_last_o,
  output vis_pkg::accum_t       vis_real_o,
  output vis_pkg::accum_t       vis_imag_o
);

  localparam int CBITS = $clog2(`VIS_LENGTH + 1);
  localparam int XBITS = `VIS_ABITS - `VIS_PBITS;

  vis_pkg::accum_state_t state_q;
  logic [CBITS-1:0]      beat_q;
  logic                  beat_end;

  // One accumulator pair per unit position
  vis_pkg::accum_t acc_re [`VIS_LENGTH];
  vis_pkg::accum_t acc_im [`VIS_LENGTH];

  // Sign-extended partials
  vis_pkg::accum_t ext_re;
  vis_pkg::accum_t ext_im;

  assign ext_re   = {{XBITS{seq_re_i[`VIS_PBITS-1]}}, seq_re_i};
  assign ext_im   = {{XBITS{seq_im_i[`VIS_PBITS-1]}}, seq_im_i};
  assign beat_end = (beat_q == CBITS'(`VIS_LENGTH - 1));

  // Beat counter and state
  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q <= vis_pkg::ST_COLLECT;
      beat_q  <= '0;
    end else begin
      case (state_q)
        vis_pkg::ST_COLLECT: begin
          if (seq_valid_i) begin
            beat_q <= beat_end ? '0 : beat_q + 1'b1;
            // Final beat of a last-tagged burst starts the dump
            if (beat_end && seq_last_i) begin
              state_q <= vis_pkg::ST_DUMP;
            end
          end
        end
        vis_pkg::ST_DUMP: begin
          beat_q <= beat_end ? '0 : beat_q + 1'b1;
          if (beat_end) begin
            state_q <= vis_pkg::ST_COLLECT;
          end
        end
        default: state_q <= vis_pkg::ST_COLLECT;
      endcase
    end
  end

  // Sums must start at zero for the first integration
  always_ff @(posedge clock) begin
    if (reset_i) begin
      for (int i = 0; i < `VIS_LENGTH; i++) begin
        acc_re[i] <= '0;
        acc_im[i] <= '0;
      end
    end else if (state_q == vis_pkg::ST_DUMP) begin
      // Each register clears as it is streamed out
      acc_re[beat_q] <= '0;
      acc_im[beat_q] <= '0;
    end else if (seq_valid_i) begin
      acc_re[beat_q] <= acc_re[beat_q] + ext_re;
      acc_im[beat_q] <= acc_im[beat_q] + ext_im;
    end
  end

  // Dump framing
  assign vis_frame_o = (state_q == vis_pkg::ST_DUMP);
  assign vis_valid_o = vis_frame_o;
  assign vis_first_o = vis_frame_o & (beat_q == '0);
  assign vis_last_o  = vis_frame_o & beat_end;
  assign vis_real_o  = acc_re[beat_q];
  assign vis_imag_o  = acc_im[beat_q];

endmodule

`default_nettype wire

// File: rtl/vis_chain.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_cfg.svh"

module vis_chain (
  input  wire              clock,
  input  wire              reset_i,
  // Upstream radio samples
  input  wire              sig_valid_i,
  input  wire              sig_first_i,
  input  wire              sig_next_i,
  input  wire              sig_emit_i,
  input  wire              sig_last_i,
  input  vis_pkg::slot_t   sig_addr_i,
  input  vis_pkg::radio_t  sig_dati_i,
  input  vis_pkg::radio_t  sig_datq_i,
  // Delayed samples for the next chain
  output logic             sig_valid_o,
  output logic             sig_first_o,
  output logic             sig_next_o,
  output logic             sig_emit_o,
  output logic             sig_last_o,
  output vis_pkg::slot_t   sig_addr_o,
  output vis_pkg::radio_t  sig_dati_o,
  output vis_pkg::radio_t  sig_datq_o,
  // Final visibilities
  output logic             vis_frame_o,
  output logic             vis_valid_o,
  output logic             vis_first_o,
  output logic             vis_last_o,
  output vis_pkg::accum_t  vis_real_o,
  output vis_pkg::accum_t  vis_imag_o
);

  sig_stream_if up_if ();
  sig_stream_if down_if ();

  // Correlator outputs, indexed by unit
  logic [`VIS_LENGTH-1:0] part_valid;
  vis_pkg::part_t         part_re [`VIS_LENGTH];
  vis_pkg::part_t         part_im [`VIS_LENGTH];

  // Merge to accumulator
  logic           seq_valid;
  logic           seq_last;
  vis_pkg::part_t seq_re;
  vis_pkg::part_t seq_im;

  // Last tag of the pending emit, ready when the units strobe
  logic emit_last_q;

  assign up_if.valid = sig_valid_i;
  assign up_if.first = sig_first_i;
  assign up_if.next  = sig_next_i;
  assign up_if.emit  = sig_emit_i;
  assign up_if.last  = sig_last_i;
  assign up_if.addr  = sig_addr_i;
  assign up_if.dati  = sig_dati_i;
  assign up_if.datq  = sig_datq_i;

  assign sig_valid_o = down_if.valid;
  assign sig_first_o = down_if.first;
  assign sig_next_o  = down_if.next;
  assign sig_emit_o  = down_if.emit;
  assign sig_last_o  = down_if.last;
  assign sig_addr_o  = down_if.addr;
  assign sig_dati_o  = down_if.dati;
  assign sig_datq_o  = down_if.datq;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      emit_last_q <= 1'b0;
    end else if (sig_valid_i && sig_emit_i) begin
      emit_last_q <= sig_last_i;
    end
  end

  // Stream travels against the visibilities
  sig_delay u_delay (
    .clock  (clock),
    .reset_i(reset_i),
    .up     (up_if.sink),
    .down   (down_if.source)
  );

  // All units see the same undelayed sample
  for (genvar k = 0; k < `VIS_LENGTH; k++) begin : g_cor
    correlator u_cor (
      .clock       (clock),
      .reset_i     (reset_i),
      .unit_i      (2'(k)),
      .strm        (up_if.sink),
      .part_valid_o(part_valid[k]),
      .part_re_o   (part_re[k]),
      .part_im_o   (part_im[k])
    );
  end

  vis_merge u_merge (
    .clock      (clock),
    .reset_i    (reset_i),
    .par_valid_i(part_valid),
    .par_re_i   (part_re),
    .par_im_i   (part_im),
    .par_last_i (emit_last_q),
    .seq_valid_o(seq_valid),
    .seq_re_o   (seq_re),
    .seq_im_o   (seq_im),
    .seq_last_o (seq_last)
  );

  vis_accum u_accum (
    .clock      (clock),
    .reset_i    (reset_i),
    .seq_valid_i(seq_valid),
    .seq_re_i   (seq_re),
    .seq_im_i   (seq_im),
    .seq_last_i (seq_last),
    .vis_frame_o(vis_frame_o),
    .vis_valid_o(vis_valid_o),
    .vis_first_o(vis_first_o),
    .vis_last_o (vis_last_o),
    .vis_real_o (vis_real_o),
    .vis_imag_o (vis_imag_o)
  );

endmodule

`default_nettype wire

// File: testbench/vis_chain_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_cfg.svh"

module vis_chain_tb;

  // One stimulus row with its data planes filled in while the table is built
  typedef struct packed {
    logic            valid;
    logic            first;
    logic            next;
    logic            emit;
    logic            last;
    logic            rnd;
    vis_pkg::slot_t  addr;
    vis_pkg::radio_t dati;
    vis_pkg::radio_t datq;
  } stim_row_t;

  // Expected final visibility with its beat inside the dump
  // Due is the cycle in which the beat must show on the outputs
  typedef struct packed {
    int              due;
    logic [3:0]      beat;
    vis_pkg::accum_t re;
    vis_pkg::accum_t im;
  } vis_exp_t;

  logic            clock;
  logic            reset_i;
  logic            sig_valid_i;
  logic            sig_first_i;
  logic            sig_next_i;
  logic            sig_emit_i;
  logic            sig_last_i;
  vis_pkg::slot_t  sig_addr_i;
  vis_pkg::radio_t sig_dati_i;
  vis_pkg::radio_t sig_datq_i;
  logic            sig_valid_o;
  logic            sig_first_o;
  logic            sig_next_o;
  logic            sig_emit_o;
  logic            sig_last_o;
  vis_pkg::slot_t  sig_addr_o;
  vis_pkg::radio_t sig_dati_o;
  vis_pkg::radio_t sig_datq_o;
  logic            vis_frame_o;
  logic            vis_valid_o;
  logic            vis_first_o;
  logic            vis_last_o;
  vis_pkg::accum_t vis_real_o;
  vis_pkg::accum_t vis_imag_o;

  stim_row_t stim [$];
  // Rows as actually driven including idle rows
  stim_row_t sent [$];
  vis_exp_t  exp_q [$];
  int        cyc;
  int        limit;

  vis_chain uut (
    .clock      (clock),
    .reset_i    (reset_i),
    .sig_valid_i(sig_valid_i),
    .sig_first_i(sig_first_i),
    .sig_next_i (sig_next_i),
    .sig_emit_i (sig_emit_i),
    .sig_last_i (sig_last_i),
    .sig_addr_i (sig_addr_i),
    .sig_dati_i (sig_dati_i),
    .sig_datq_i (sig_datq_i),
    .sig_valid_o(sig_valid_o),
    .sig_first_o(sig_first_o),
    .sig_next_o (sig_next_o),
    .sig_emit_o (sig_emit_o),
    .sig_last_o (sig_last_o),
    .sig_addr_o (sig_addr_o),
    .sig_dati_o (sig_dati_o),
    .sig_datq_o (sig_datq_o),
    .vis_frame_o(vis_frame_o),
    .vis_valid_o(vis_valid_o),
    .vis_first_o(vis_first_o),
    .vis_last_o (vis_last_o),
    .vis_real_o (vis_real_o),
    .vis_imag_o (vis_imag_o)
  );

  // 20 ns clock
  always #10 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_value(input string name, input string exp_s, input string act_s);
    abort_run($sformatf("error at %0t: %s expected %s, got %s", $realtime, name, exp_s, act_s));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) report_value(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_vis(input string name, input vis_pkg::accum_t exp,
                           input vis_pkg::accum_t act);
    if (act !== exp) report_value(name, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  // Every field of the forwarded stream including the data planes
  task automatic check_stream(input stim_row_t exp, input stim_row_t act);
    check_flag("sig_valid_o", exp.valid, act.valid);
    check_flag("sig_first_o", exp.first, act.first);
    check_flag("sig_next_o", exp.next, act.next);
    check_flag("sig_emit_o", exp.emit, act.emit);
    check_flag("sig_last_o", exp.last, act.last);
    if (act.addr !== exp.addr)
      report_value("sig_addr_o", $sformatf("%h", exp.addr), $sformatf("%h", act.addr));
    if (act.dati !== exp.dati)
      report_value("sig_dati_o", $sformatf("%h", exp.dati), $sformatf("%h", act.dati));
    if (act.datq !== exp.datq)
      report_value("sig_datq_o", $sformatf("%h", exp.datq), $sformatf("%h", act.datq));
  endtask

  task automatic add_row(input logic valid, input logic first, input logic emit,
                         input logic last, input int addr, input logic rnd);
    stim_row_t r;
    int        n;
    n = stim.size();
    r = '0;
    r.valid = valid;
    r.first = first;
    r.emit  = emit;
    r.last  = last;
    r.rnd   = rnd;
    r.addr  = vis_pkg::slot_t'(addr);
    r.next  = 1'($urandom());
    if (rnd) begin
      r.dati = vis_pkg::radio_t'($urandom());
      r.datq = vis_pkg::radio_t'($urandom());
    end else begin
      // All radios carry the same bit
      r.dati = n[0] ? '1 : '0;
      r.datq = n[1] ? '1 : '0;
    end
    stim.push_back(r);
  endtask

  // One sample period with slots in order
  // An emit_slot of -1 means no emit
  task automatic add_period(input logic first, input int emit_slot, input logic last,
                            input logic rnd);
    for (int t = 0; t < `VIS_TRATE; t++) begin
      add_row(1'b1, first && t == 0, t == emit_slot, last && t == emit_slot, t, rnd);
    end
  endtask

  task automatic add_idle(input int count);
    for (int i = 0; i < count; i++) begin
      add_row(1'b0, 1'b0, 1'b0, 1'b0, 0, 1'b1);
    end
  endtask

  task automatic build_table();
    add_idle(2);
    // Identical radios in one integration
    add_period(1'b1, -1, 1'b0, 1'b0);
    add_period(1'b0, 3, 1'b1, 1'b0);
    add_idle(3);
    // Random data with several bursts in one integration
    add_period(1'b1, -1, 1'b0, 1'b1);
    add_period(1'b0, 1, 1'b0, 1'b1);
    add_period(1'b0, 5, 1'b0, 1'b1);
    add_period(1'b0, 6, 1'b1, 1'b1);
    // Mid-run first throws away the period before it
    add_period(1'b1, -1, 1'b0, 1'b1);
    add_period(1'b1, -1, 1'b0, 1'b1);
    add_period(1'b0, 2, 1'b1, 1'b1);
    // Back-to-back integration
    add_period(1'b1, -1, 1'b0, 1'b1);
    add_period(1'b0, 4, 1'b1, 1'b1);
    add_idle(2);
  endtask

  // Bit as +1 or -1
  function automatic int bit_val(input logic b);
    return b ? 1 : -1;
  endfunction

  // Reference model of a times conj(b) per baseline and slot
  task automatic build_expected();
    int       slot_re [`VIS_LENGTH][`VIS_TRATE];
    int       slot_im [`VIS_LENGTH][`VIS_TRATE];
    int       acc_re [`VIS_LENGTH];
    int       acc_im [`VIS_LENGTH];
    int       t;
    int       b;
    vis_exp_t e;
    for (int k = 0; k < `VIS_LENGTH; k++) begin
      acc_re[k] = 0;
      acc_im[k] = 0;
      for (int s = 0; s < `VIS_TRATE; s++) begin
        slot_re[k][s] = 0;
        slot_im[k][s] = 0;
      end
    end
    foreach (stim[n]) begin
      if (stim[n].valid) begin
        t = stim[n].addr;
        for (int k = 0; k < `VIS_LENGTH; k++) begin
          if (stim[n].first) begin
            for (int s = 0; s < `VIS_TRATE; s++) begin
              slot_re[k][s] = 0;
              slot_im[k][s] = 0;
            end
          end
          b = (t + k + 1) % `VIS_RADIOS;
          slot_re[k][t] += bit_val(stim[n].dati[t]) * bit_val(stim[n].dati[b])
                         + bit_val(stim[n].datq[t]) * bit_val(stim[n].datq[b]);
          slot_im[k][t] += bit_val(stim[n].datq[t]) * bit_val(stim[n].dati[b])
                         - bit_val(stim[n].dati[t]) * bit_val(stim[n].datq[b]);
          // Emit hands the slot sum to the accumulator
          if (stim[n].emit) begin
            acc_re[k] += slot_re[k][t];
            acc_im[k] += slot_im[k][t];
            slot_re[k][t] = 0;
            slot_im[k][t] = 0;
          end
        end
        if (stim[n].emit && stim[n].last) begin
          for (int k = 0; k < `VIS_LENGTH; k++) begin
            // Units strobe one cycle after the row and the merge beats follow
            // The dump starts right after the final merge beat
            e.due  = n + 2 + `VIS_LENGTH + k;
            e.beat = 4'(k);
            e.re   = vis_pkg::accum_t'(acc_re[k]);
            e.im   = vis_pkg::accum_t'(acc_im[k]);
            exp_q.push_back(e);
            acc_re[k] = 0;
            acc_im[k] = 0;
          end
        end
      end
    end
  endtask

  task automatic drive_row(input stim_row_t r);
    sig_valid_i = r.valid;
    sig_first_i = r.first;
    sig_next_i  = r.next;
    sig_emit_i  = r.emit;
    sig_last_i  = r.last;
    sig_addr_i  = r.addr;
    sig_dati_i  = r.dati;
    sig_datq_i  = r.datq;
  endtask

  // Past the table the stream idles with zero data
  task automatic apply_row(input int n);
    stim_row_t r;
    r = (n < stim.size()) ? stim[n] : '0;
    drive_row(r);
    sent.push_back(r);
  endtask

  task automatic check_cycle(input int c);
    stim_row_t seen;
    vis_exp_t  e;
    logic      exp_vis;
    if (c >= `VIS_LENGTH) begin
      seen = '0;
      seen.valid = sig_valid_o;
      seen.first = sig_first_o;
      seen.next  = sig_next_o;
      seen.emit  = sig_emit_o;
      seen.last  = sig_last_o;
      seen.addr  = sig_addr_o;
      seen.dati  = sig_dati_o;
      seen.datq  = sig_datq_o;
      check_stream(sent[c - `VIS_LENGTH], seen);
    end
    // A dump beat is due only in the cycle the model gives it
    exp_vis = (exp_q.size() != 0) && (exp_q[0].due == c);
    check_flag("vis_valid_o", exp_vis, vis_valid_o);
    check_flag("vis_frame_o", exp_vis, vis_frame_o);
    if (exp_vis) begin
      e = exp_q.pop_front();
      check_flag("vis_first_o", e.beat == 0, vis_first_o);
      check_flag("vis_last_o", e.beat == `VIS_LENGTH - 1, vis_last_o);
      check_vis("vis_real_o", e.re, vis_real_o);
      check_vis("vis_imag_o", e.im, vis_imag_o);
    end else begin
      check_flag("vis_first_o", 1'b0, vis_first_o);
      check_flag("vis_last_o", 1'b0, vis_last_o);
    end
  endtask

  initial begin
    clock     = 1'b0;
    reset_i   = 1'b1;
    drive_row('0);
    void'($urandom(50));
    build_table();
    build_expected();
    limit = stim.size() + 4 * `VIS_LENGTH + 20;
    repeat (16) @(posedge clock);
    // Everything low while reset is held
    #1;
    check_flag("sig_valid_o", 1'b0, sig_valid_o);
    check_flag("sig_first_o", 1'b0, sig_first_o);
    check_flag("sig_emit_o", 1'b0, sig_emit_o);
    check_flag("sig_last_o", 1'b0, sig_last_o);
    check_flag("vis_frame_o", 1'b0, vis_frame_o);
    check_flag("vis_valid_o", 1'b0, vis_valid_o);
    check_flag("vis_first_o", 1'b0, vis_first_o);
    check_flag("vis_last_o", 1'b0, vis_last_o);
    #1;
    reset_i = 1'b0;
    cyc = 0;
    apply_row(0);
    while (!(exp_q.size() == 0 && cyc >= stim.size() + `VIS_LENGTH)) begin
      @(posedge clock);
      cyc++;
      if (cyc > limit)
        abort_run($sformatf("Timeout after %0d cycles, %0d visibilities never arrived",
                            cyc, exp_q.size()));
      // Sample just after the edge and drive a little later
      #1;
      check_cycle(cyc);
      #1;
      apply_row(cyc);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/vis_pkg.sv
rtl/sig_stream_if.sv
rtl/sig_delay.sv
rtl/correlator.sv
rtl/vis_merge.sv
rtl/vis_accum.sv
rtl/vis_chain.sv
testbench/vis_chain_tb.sv

// File: Bender.yml
package:
  name: vis_chain

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vis_pkg.sv
      - rtl/sig_stream_if.sv
      - rtl/sig_delay.sv
      - rtl/correlator.sv
      - rtl/vis_merge.sv
      - rtl/vis_accum.sv
      - rtl/vis_chain.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/vis_chain_tb.sv
